/* src/servo_pkg.sv */
package servo_pkg;

    // Datapath widths
    localparam int SAMPLE_W = 16;
    localparam int COEF_W = 35;
    localparam int COEF_FRAC = 26;
    localparam int STEP_W = 32;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [COEF_W-1:0] coef_t;

    // Loadable register addresses
    typedef enum logic [3:0] {
        PD_A1, PD_B0, PD_B1,
        PI_A1, PI_B0, PI_B1,
        LP_A1, LP_B0,
        MIN_LEVEL, SWEEP_MIN, SWEEP_MAX, SWEEP_STEP, ERR_OFFSET
    } param_addr_t;

    // One load word, read as a coefficient or as step plus padding
    typedef union packed {
        coef_t coef;
        struct packed {
            logic [STEP_W-1:0]        step;
            logic [COEF_W-STEP_W-1:0] pad;
        } split;
    } param_word_u;

    ////////////////////////////////////////////////////////////
    // Reset defaults
    ////////////////////////////////////////////////////////////

    localparam real PI_R = 3.14159265358979;
    localparam real TS = 1.0e-8;
    localparam real SCALE = 2.0 ** COEF_FRAC;
    localparam real FULL_SCALE = 32767.0;

    // Transmission low-pass, 1 kHz corner, unity gain
    localparam real LP_F0 = 1.0e3;
    localparam real LP_W = PI_R * LP_F0 * TS;
    localparam int LP_A1_DEF = int'((1.0 - LP_W) / (1.0 + LP_W) * SCALE);
    localparam int LP_B0_DEF = int'(LP_W / (1.0 + LP_W) * SCALE);

    // Servo shaping terms
    localparam real SV_P = 0.06;
    localparam real SV_PI = 1.0;
    localparam real SV_I = 400.0;
    localparam real SV_D = 0.7e-6;
    localparam real SV_FC = 1.0e5;
    localparam real FC_W = PI_R * TS * SV_FC;
    // Derivative with roll-off at SV_FC
    localparam int PD_A1_DEF = int'((1.0 - 2.0 * FC_W) * SCALE);
    localparam int PD_B0_DEF =
        int'((SV_D / SV_PI * SV_FC / (1.0 + FC_W) + SV_P * FC_W / (1.0 + FC_W)) * SCALE);
    localparam int PD_B1_DEF =
        int'((SV_P * FC_W / (1.0 + FC_W) - SV_D / SV_PI * SV_FC / (1.0 + FC_W)) * SCALE);
    // Pure integrator, pole at one
    localparam int PI_A1_DEF = 1 << COEF_FRAC;
    localparam int PI_B0_DEF = int'((SV_PI + SV_I * PI_R * TS / SV_P) * SCALE);
    localparam int PI_B1_DEF = int'((SV_I * PI_R * TS / SV_P - SV_PI) * SCALE);

    // Levels as fractions of full scale
    localparam int MIN_LEVEL_DEF = int'(0.25 * FULL_SCALE);
    localparam int SWEEP_MIN_DEF = int'(0.1875 * FULL_SCALE);
    localparam int SWEEP_MAX_DEF = int'(0.65625 * FULL_SCALE);
    // One LSB of position every 2^25 cycles
    localparam int SWEEP_STEP_DEF = 128;
    // Roughly -2 mV
    localparam int ERR_OFFSET_DEF = int'(-0.002 * FULL_SCALE);

endpackage

/* src/param_if.sv */
interface param_if;
    import servo_pkg::*;

    // PD then PI stage coefficients
    coef_t pd_a1;
    coef_t pd_b0;
    coef_t pd_b1;
    coef_t pi_a1;
    coef_t pi_b0;
    coef_t pi_b1;

    // Transmission low-pass
    coef_t lp_a1;
    coef_t lp_b0;

    // Levels and sweep setup
    sample_t min_level;
    sample_t sweep_min;
    sample_t sweep_max;
    sample_t err_offset;
    logic [STEP_W-1:0] sweep_step;

    modport bank (
        output pd_a1, pd_b0, pd_b1, pi_a1, pi_b0, pi_b1, lp_a1, lp_b0,
        output min_level, sweep_min, sweep_max, err_offset, sweep_step
    );

    modport sink (
        input pd_a1, pd_b0, pd_b1, pi_a1, pi_b0, pi_b1, lp_a1, lp_b0,
        input min_level, sweep_min, sweep_max, err_offset, sweep_step
    );

endinterface

/* src/iir_stage.sv */
module iir_stage (
    input  logic             clk_in,
    input  logic             reset,
    input  logic             on,
    input  logic             hold,
    input  servo_pkg::coef_t   a1,
    input  servo_pkg::coef_t   b0,
    input  servo_pkg::coef_t   b1,
    input  servo_pkg::sample_t x,
    output servo_pkg::sample_t y
);
    import servo_pkg::*;

    // Product plus two bits of growth for the three-term sum
    localparam int SUM_W = COEF_W + SAMPLE_W + 2;
    localparam logic signed [SUM_W-1:0] SAT_HI = SUM_W'(2 ** (SAMPLE_W - 1) - 1);
    localparam logic signed [SUM_W-1:0] SAT_LO = -SAT_HI - 1;

    sample_t x_prev;
    logic signed [SUM_W-1:0] acc;
    logic signed [SUM_W-1:0] shifted;
    sample_t y_next;

    ////////////////////////////////////////////////////////////
    // Difference equation
    ////////////////////////////////////////////////////////////

    always_comb begin
        // y[n] = a1*y[n-1] + b0*x[n] + b1*x[n-1]
        acc = SUM_W'(a1) * SUM_W'(y)
            + SUM_W'(b0) * SUM_W'(x)
            + SUM_W'(b1) * SUM_W'(x_prev);
        // Drop the coefficient fraction
        shifted = acc >>> COEF_FRAC;
        // Clip to the sample range
        if (shifted > SAT_HI) begin
            y_next = sample_t'(SAT_HI);
        end else if (shifted < SAT_LO) begin
            y_next = sample_t'(SAT_LO);
        end else begin
            y_next = shifted[SAMPLE_W-1:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // State registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (reset || !on) begin
            // Stage off flushes its history
            y <= '0;
            x_prev <= '0;
        end else if (!hold) begin
            y <= y_next;
            x_prev <= x;
        end
    end

endmodule

/* src/param_bank.sv */
module param_bank (
    input  logic                   clk_in,
    input  logic                   reset,
    input  logic                   param_load,
    input  servo_pkg::param_addr_t param_addr,
    input  servo_pkg::param_word_u param_word,
    param_if.bank                  p
);
    import servo_pkg::*;

    // Levels use the bottom of the coefficient view
    sample_t word_level;

    assign word_level = param_word.coef[SAMPLE_W-1:0];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            // Servo shaping
            p.pd_a1 <= coef_t'(PD_A1_DEF);
            p.pd_b0 <= coef_t'(PD_B0_DEF);
            p.pd_b1 <= coef_t'(PD_B1_DEF);
            p.pi_a1 <= coef_t'(PI_A1_DEF);
            p.pi_b0 <= coef_t'(PI_B0_DEF);
            p.pi_b1 <= coef_t'(PI_B1_DEF);
            // Transmission filter
            p.lp_a1 <= coef_t'(LP_A1_DEF);
            p.lp_b0 <= coef_t'(LP_B0_DEF);
            // Thresholds and sweep
            p.min_level <= sample_t'(MIN_LEVEL_DEF);
            p.sweep_min <= sample_t'(SWEEP_MIN_DEF);
            p.sweep_max <= sample_t'(SWEEP_MAX_DEF);
            p.sweep_step <= STEP_W'(SWEEP_STEP_DEF);
            p.err_offset <= sample_t'(ERR_OFFSET_DEF);
        end else if (param_load) begin
            // One register per strobe
            case (param_addr)
                PD_A1:      p.pd_a1 <= param_word.coef;
                PD_B0:      p.pd_b0 <= param_word.coef;
                PD_B1:      p.pd_b1 <= param_word.coef;
                PI_A1:      p.pi_a1 <= param_word.coef;
                PI_B0:      p.pi_b0 <= param_word.coef;
                PI_B1:      p.pi_b1 <= param_word.coef;
                LP_A1:      p.lp_a1 <= param_word.coef;
                LP_B0:      p.lp_b0 <= param_word.coef;
                MIN_LEVEL:  p.min_level <= word_level;
                SWEEP_MIN:  p.sweep_min <= word_level;
                SWEEP_MAX:  p.sweep_max <= word_level;
                // Step sits above three padding bits
                SWEEP_STEP: p.sweep_step <= param_word.split.step;
                ERR_OFFSET: p.err_offset <= word_level;
                // Spare addresses do nothing
                default: begin
                end
            endcase
        end
    end

endmodule

/* src/relock_sweep.sv */
module relock_sweep (
    input  logic               clk_in,
    input  logic               reset,
    input  servo_pkg::sample_t trans_lp,
    param_if.sink              p,
    output logic               relock_on,
    output servo_pkg::sample_t sweep
);
    import servo_pkg::*;

    // Position on top, fraction below
    localparam int ACC_W = SAMPLE_W + STEP_W;
    localparam logic [ACC_W-1:0] ACC_START = {sample_t'(SWEEP_MIN_DEF), {STEP_W{1'b0}}};

    logic [ACC_W-1:0] acc;
    logic dir_down;

    // One extra bit so a step past full scale cannot wrap
    logic signed [ACC_W:0] acc_ext;
    logic signed [ACC_W:0] step_ext;
    logic signed [ACC_W:0] stepped;
    logic signed [SAMPLE_W:0] pos_next;
    logic signed [SAMPLE_W:0] max_ext;
    logic signed [SAMPLE_W:0] min_ext;

    ////////////////////////////////////////////////////////////
    // Low transmission detect
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (reset) begin
            relock_on <= 1'b0;
        end else begin
            // Strictly below the minimum
            relock_on <= (trans_lp < p.min_level);
        end
    end

    ////////////////////////////////////////////////////////////
    // Triangle sweep
    ////////////////////////////////////////////////////////////

    assign acc_ext = {acc[ACC_W-1], acc};
    assign step_ext = {{(SAMPLE_W + 1){1'b0}}, p.sweep_step};
    assign stepped = dir_down ? acc_ext - step_ext : acc_ext + step_ext;
    // Candidate position after this step
    assign pos_next = stepped[ACC_W:STEP_W];
    assign max_ext = {p.sweep_max[SAMPLE_W-1], p.sweep_max};
    assign min_ext = {p.sweep_min[SAMPLE_W-1], p.sweep_min};

    always_ff @(posedge clk_in) begin
        if (reset) begin
            acc <= ACC_START;
            dir_down <= 1'b0;
        end else if (relock_on) begin
            if (!dir_down && pos_next >= max_ext) begin
                // Top reached, park on the limit and turn
                acc <= {p.sweep_max, {STEP_W{1'b0}}};
                dir_down <= 1'b1;
            end else if (dir_down && pos_next <= min_ext) begin
                // Bottom reached
                acc <= {p.sweep_min, {STEP_W{1'b0}}};
                dir_down <= 1'b0;
            end else begin
                acc <= stepped[ACC_W-1:0];
            end
        end
        // Lock held, sweep frozen where it is
    end

    assign sweep = acc[ACC_W-1:STEP_W];

endmodule

/* src/lock_status.sv */
module lock_status #(
    parameter int HOLDOFF_CYCLES = 100_000_000
) (
    input  logic clk_in,
    input  logic reset,
    input  logic relock_on,
    output logic unlocked,
    output logic recent_unlock
);

    // State encodings
    localparam logic [1:0] LOCKED = 2'd0;
    localparam logic [1:0] UNLOCKED = 2'd1;
    localparam logic [1:0] SETTLING = 2'd2;

    // Hold-off counter sized to the cycle count
    localparam int CNT_W = (HOLDOFF_CYCLES > 1) ? $clog2(HOLDOFF_CYCLES) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(HOLDOFF_CYCLES - 1);

    logic [1:0] state;
    logic [CNT_W-1:0] count;
    logic count_run;

    // Counting only while settling and still above threshold
    assign count_run = (state == SETTLING) && !relock_on && (count != LAST);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= LOCKED;
            count <= '0;
        end else begin
            case (state)
                LOCKED: begin
                    if (relock_on) begin
                        state <= UNLOCKED;
                    end
                end
                UNLOCKED: begin
                    if (!relock_on) begin
                        state <= SETTLING;
                    end
                end
                SETTLING: begin
                    // Dropout restarts the hold-off
                    if (relock_on) begin
                        state <= UNLOCKED;
                    end else if (count == LAST) begin
                        state <= LOCKED;
                    end
                end
                default: state <= LOCKED;
            endcase
            // SETTLING lasts exactly HOLDOFF_CYCLES cycles
            count <= count_run ? count + CNT_W'(1) : '0;
        end
    end

    assign unlocked = (state == UNLOCKED);
    assign recent_unlock = (state == UNLOCKED) || (state == SETTLING);

endmodule

/* src/pid_servo.sv */
module pid_servo (
    input  logic               clk_in,
    input  logic               reset,
    input  logic               on,
    input  servo_pkg::sample_t err,
    param_if.sink              p,
    output servo_pkg::sample_t servo_out
);
    import servo_pkg::*;

    sample_t err_adj;
    sample_t pd_out;

    // Offset removal, wraps at 16 bits
    assign err_adj = err - p.err_offset;

    // PD stage
    iir_stage pd_stage (
        .clk_in (clk_in),
        .reset  (reset),
        .on     (on),
        .hold   (1'b0),
        .a1     (p.pd_a1),
        .b0     (p.pd_b0),
        .b1     (p.pd_b1),
        .x      (err_adj),
        .y      (pd_out)
    );

    // PI stage fed from the PD output, one more cycle
    iir_stage pi_stage (
        .clk_in (clk_in),
        .reset  (reset),
        .on     (on),
        .hold   (1'b0),
        .a1     (p.pi_a1),
        .b0     (p.pi_b0),
        .b1     (p.pi_b1),
        .x      (pd_out),
        .y      (servo_out)
    );

endmodule

/* src/lock_servo_top.sv */
module lock_servo_top #(
    parameter int HOLDOFF_CYCLES = 100_000_000
) (
    input  logic                   clk_in,
    input  logic                   reset,
    input  servo_pkg::sample_t     trans_in,
    input  servo_pkg::sample_t     err_in,
    input  logic                   param_load,
    input  servo_pkg::param_addr_t param_addr,
    input  servo_pkg::param_word_u param_word,
    output servo_pkg::sample_t     trans_lp_out,
    output servo_pkg::sample_t     drive_out,
    output logic                   unlocked,
    output logic                   recent_unlock
);
    import servo_pkg::*;

    param_if p ();

    logic relock_on;
    logic servo_on;
    sample_t sweep;
    sample_t servo_out;

    // Servo runs only with enough transmission
    assign servo_on = ~relock_on;

    param_bank u_bank (
        .clk_in     (clk_in),
        .reset      (reset),
        .param_load (param_load),
        .param_addr (param_addr),
        .param_word (param_word),
        .p          (p)
    );

    ////////////////////////////////////////////////////////////
    // Transmission path
    ////////////////////////////////////////////////////////////

    // Bilinear low-pass, b1 equal to b0
    iir_stage u_lowpass (
        .clk_in (clk_in),
        .reset  (reset),
        .on     (1'b1),
        .hold   (1'b0),
        .a1     (p.lp_a1),
        .b0     (p.lp_b0),
        .b1     (p.lp_b0),
        .x      (trans_in),
        .y      (trans_lp_out)
    );

    relock_sweep u_sweep (
        .clk_in    (clk_in),
        .reset     (reset),
        .trans_lp  (trans_lp_out),
        .p         (p),
        .relock_on (relock_on),
        .sweep     (sweep)
    );

    lock_status #(
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) u_status (
        .clk_in        (clk_in),
        .reset         (reset),
        .relock_on     (relock_on),
        .unlocked      (unlocked),
        .recent_unlock (recent_unlock)
    );

    ////////////////////////////////////////////////////////////
    // Error path and drive
    ////////////////////////////////////////////////////////////

    pid_servo u_servo (
        .clk_in    (clk_in),
        .reset     (reset),
        .on        (servo_on),
        .err       (err_in),
        .p         (p),
        .servo_out (servo_out)
    );

    // Frozen sweep plus servo correction, wrapping
    always_ff @(posedge clk_in) begin
        if (reset) begin
            drive_out <= '0;
        end else begin
            drive_out <= sweep + servo_out;
        end
    end

endmodule

/* verif/servo_model.svh */
`ifndef SERVO_MODEL_SVH
`define SERVO_MODEL_SVH

// Lock FSM codes of the model
localparam int ST_LOCKED = 0;
localparam int ST_UNLOCKED = 1;
localparam int ST_SETTLING = 2;

// Parameter copies, coefficients indexed by load address
coef_t m_coef [0:15];
sample_t m_min_level;
sample_t m_sweep_min;
sample_t m_sweep_max;
sample_t m_err_offset;
logic [STEP_W-1:0] m_step;

// Register mirrors
sample_t m_lp_y;
sample_t m_lp_x;
sample_t m_pd_y;
sample_t m_pd_x;
sample_t m_pi_y;
sample_t m_pi_x;
sample_t m_drive;
logic m_relock;
// Sweep position scaled by 2^32, fraction in the low bits
longint m_acc;
logic m_down;
int m_state;
// Cycles spent so far in SETTLING
int m_settle;
logic model_valid = 1'b0;

////////////////////////////////////////////////////////////
// Arithmetic helpers
////////////////////////////////////////////////////////////

// First-order section, floor shift then clip to 16 bits
function automatic sample_t iir_next(input coef_t a1, input coef_t b0, input coef_t b1,
                                     input sample_t y_prev, input sample_t x,
                                     input sample_t x_prev);
    longint sum;
    sum = longint'(a1) * longint'(y_prev) + longint'(b0) * longint'(x)
        + longint'(b1) * longint'(x_prev);
    sum = sum >>> COEF_FRAC;
    if (sum > 64'sd32767) begin
        return sample_t'(16'sh7fff);
    end
    if (sum < -64'sd32768) begin
        return sample_t'(16'sh8000);
    end
    return sample_t'(sum);
endfunction

// Whole-LSB part of the sweep
function automatic sample_t sweep_pos(input longint acc);
    return sample_t'(acc >>> STEP_W);
endfunction

////////////////////////////////////////////////////////////
// One clock edge of the whole channel
////////////////////////////////////////////////////////////

task automatic model_step(input logic rst, input sample_t trans, input sample_t err,
                          input logic load, input logic [3:0] addr,
                          input logic [COEF_W-1:0] word);
    sample_t lp_next;
    sample_t err_adj;
    logic relock_next;
    longint cand;
    longint cand_pos;
    if (rst) begin
        m_coef[PD_A1] = coef_t'(PD_A1_DEF);
        m_coef[PD_B0] = coef_t'(PD_B0_DEF);
        m_coef[PD_B1] = coef_t'(PD_B1_DEF);
        m_coef[PI_A1] = coef_t'(PI_A1_DEF);
        m_coef[PI_B0] = coef_t'(PI_B0_DEF);
        m_coef[PI_B1] = coef_t'(PI_B1_DEF);
        m_coef[LP_A1] = coef_t'(LP_A1_DEF);
        m_coef[LP_B0] = coef_t'(LP_B0_DEF);
        m_min_level = sample_t'(MIN_LEVEL_DEF);
        m_sweep_min = sample_t'(SWEEP_MIN_DEF);
        m_sweep_max = sample_t'(SWEEP_MAX_DEF);
        m_err_offset = sample_t'(ERR_OFFSET_DEF);
        m_step = STEP_W'(SWEEP_STEP_DEF);
        m_lp_y = '0;
        m_lp_x = '0;
        m_pd_y = '0;
        m_pd_x = '0;
        m_pi_y = '0;
        m_pi_x = '0;
        m_drive = '0;
        m_relock = 1'b0;
        // Sweep parked at the bottom, heading up
        m_acc = longint'(sample_t'(SWEEP_MIN_DEF)) <<< STEP_W;
        m_down = 1'b0;
        m_state = ST_LOCKED;
        m_settle = 0;
        model_valid = 1'b1;
    end else begin
        // Low-pass with b1 equal to b0
        lp_next = iir_next(m_coef[LP_A1], m_coef[LP_B0], m_coef[LP_B0], m_lp_y, trans, m_lp_x);
        relock_next = (m_lp_y < m_min_level);
        // Drive sees last cycle's sweep and PI output
        m_drive = sweep_pos(m_acc) + m_pi_y;
        // PI first since it reads the old PD output
        if (m_relock) begin
            m_pd_y = '0;
            m_pd_x = '0;
            m_pi_y = '0;
            m_pi_x = '0;
        end else begin
            err_adj = err - m_err_offset;
            m_pi_y = iir_next(m_coef[PI_A1], m_coef[PI_B0], m_coef[PI_B1], m_pi_y, m_pd_y,
                              m_pi_x);
            m_pi_x = m_pd_y;
            m_pd_y = iir_next(m_coef[PD_A1], m_coef[PD_B0], m_coef[PD_B1], m_pd_y, err_adj,
                              m_pd_x);
            m_pd_x = err_adj;
        end
        // Triangle scan only while lock is lost
        if (m_relock) begin
            cand = m_down ? m_acc - longint'(m_step) : m_acc + longint'(m_step);
            cand_pos = cand >>> STEP_W;
            if (!m_down && cand_pos >= longint'(m_sweep_max)) begin
                m_acc = longint'(m_sweep_max) <<< STEP_W;
                m_down = 1'b1;
            end else if (m_down && cand_pos <= longint'(m_sweep_min)) begin
                m_acc = longint'(m_sweep_min) <<< STEP_W;
                m_down = 1'b0;
            end else begin
                m_acc = cand;
            end
        end
        // Lock indicator
        case (m_state)
            ST_LOCKED: begin
                if (m_relock) begin
                    m_state = ST_UNLOCKED;
                end
            end
            ST_UNLOCKED: begin
                if (!m_relock) begin
                    m_state = ST_SETTLING;
                    m_settle = 1;
                end
            end
            default: begin
                if (m_relock) begin
                    m_state = ST_UNLOCKED;
                end else if (m_settle == HOLDOFF) begin
                    m_state = ST_LOCKED;
                end else begin
                    m_settle = m_settle + 1;
                end
            end
        endcase
        m_lp_y = lp_next;
        m_lp_x = trans;
        m_relock = relock_next;
        // Loaded value counts from the next edge on
        if (load) begin
            case (addr)
                MIN_LEVEL: m_min_level = sample_t'(word[SAMPLE_W-1:0]);
                SWEEP_MIN: m_sweep_min = sample_t'(word[SAMPLE_W-1:0]);
                SWEEP_MAX: m_sweep_max = sample_t'(word[SAMPLE_W-1:0]);
                SWEEP_STEP: m_step = word[COEF_W-1:COEF_W-STEP_W];
                ERR_OFFSET: m_err_offset = sample_t'(word[SAMPLE_W-1:0]);
                default: begin
                    // Coefficients live at the low addresses
                    if (addr <= 4'(LP_B0)) begin
                        m_coef[addr] = coef_t'(word);
                    end
                end
            endcase
        end
    end
endtask

`endif

/* verif/tb_lock_servo.sv */
module tb_lock_servo;
    timeunit 1ns;
    timeprecision 1ps;
    import servo_pkg::*;

    localparam int HOLDOFF = 64;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_PHASES = 10;
    localparam int PHASE_LEN = 200;
    localparam int TOTAL_CYCLES = RESET_CYCLES + NUM_PHASES * PHASE_LEN;
    localparam int TIMEOUT_CYCLES = TOTAL_CYCLES + 100;

    logic clk_in;
    logic reset;
    sample_t trans_in;
    sample_t err_in;
    logic param_load;
    param_addr_t param_addr;
    param_word_u param_word;
    sample_t trans_lp_out;
    sample_t drive_out;
    logic unlocked;
    logic recent_unlock;

    integer seed = 32'h2a6e_5b8b;
    int cycle_count = 0;

    `include "servo_model.svh"

    lock_servo_top #(
        .HOLDOFF_CYCLES (HOLDOFF)
    ) uut (
        .clk_in        (clk_in),
        .reset         (reset),
        .trans_in      (trans_in),
        .err_in        (err_in),
        .param_load    (param_load),
        .param_addr    (param_addr),
        .param_word    (param_word),
        .trans_lp_out  (trans_lp_out),
        .drive_out     (drive_out),
        .unlocked      (unlocked),
        .recent_unlock (recent_unlock)
    );

    // 4 ns clock
    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + r % (hi - lo + 1);
    endfunction

    // Transmission level by phase
    function automatic sample_t trans_sample(input int ph, input int cyc);
        case (ph)
            1, 5: return sample_t'(rand_range(0, 3000));
            // Two short dips with the second one inside the hold-off
            4: begin
                if ((cyc >= 20 && cyc < 24) || (cyc >= 60 && cyc < 64)) begin
                    return sample_t'(rand_range(0, 1000));
                end
                return sample_t'(rand_range(14000, 20000));
            end
            6: return sample_t'(rand_range(28000, 32767));
            7: return sample_t'(rand_range(-32768, -28000));
            // Hovering around the raised threshold
            8: return sample_t'(rand_range(4000, 20000));
            default: return sample_t'(rand_range(12000, 20000));
        endcase
    endfunction

    task automatic load_word(input param_addr_t addr, input int value);
        param_load = 1'b1;
        param_addr = addr;
        param_word.coef = coef_t'(value);
    endtask

    // Step rides in the top 32 bits
    task automatic load_step(input logic [STEP_W-1:0] step);
        param_load = 1'b1;
        param_addr = SWEEP_STEP;
        param_word.split.step = step;
        param_word.split.pad = '0;
    endtask

    task automatic drive_loads(input int ph, input int cyc);
        // Idle bus carries junk
        param_load = 1'b0;
        param_addr = param_addr_t'(4'(rand_range(0, 15)));
        param_word.coef = coef_t'($random(seed));
        case (ph)
            1: begin
                // Fast unity-gain low-pass and a narrow sweep window
                case (cyc)
                    0: load_word(LP_A1, 1 << 25);
                    1: load_word(LP_B0, 1 << 24);
                    2: load_word(SWEEP_MIN, 1000);
                    3: load_word(SWEEP_MAX, 1040);
                    4: load_step(32'hc000_0000);
                    5: load_word(MIN_LEVEL, 6000);
                    6: load_word(param_addr_t'(4'd14), 12345);
                    default: begin
                    end
                endcase
            end
            3: begin
                // Mild PD and leaky PI
                case (cyc)
                    0: load_word(PD_A1, 0);
                    1: load_word(PD_B0, 1 << 25);
                    2: load_word(PD_B1, -(1 << 24));
                    3: load_word(PI_A1, 1 << 25);
                    4: load_word(PI_B0, 1 << 24);
                    5: load_word(PI_B1, 1 << 24);
                    6: load_word(ERR_OFFSET, -100);
                    default: begin
                    end
                endcase
            end
            6: begin
                // DC gain of four drives the filter into its rails
                if (cyc == 0) begin
                    load_word(LP_B0, 1 << 26);
                end
            end
            8: begin
                case (cyc)
                    0: load_word(LP_B0, 1 << 24);
                    1: load_word(MIN_LEVEL, 12000);
                    2: load_word(SWEEP_MAX, 1100);
                    default: begin
                    end
                endcase
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_value(input string name, input logic signed [31:0] got,
                               input logic signed [31:0] exp);
        assert (got === exp) else begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Model update and output compare
    ////////////////////////////////////////////////////////////

    always @(posedge clk_in) begin
        model_step(reset, trans_in, err_in, param_load, param_addr, param_word);
    end

    // Mid-cycle where the outputs are stable
    always @(negedge clk_in) begin
        if (model_valid) begin
            check_value("trans_lp_out", 32'(trans_lp_out), 32'(m_lp_y));
            check_value("drive_out", 32'(drive_out), 32'(m_drive));
            check_value("unlocked", 32'(unlocked), (m_state == ST_UNLOCKED) ? 1 : 0);
            check_value("recent_unlock", 32'(recent_unlock), (m_state != ST_LOCKED) ? 1 : 0);
        end
    end

    initial begin
        while (cycle_count <= TIMEOUT_CYCLES) begin
            @(posedge clk_in);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $fatal(1, "Run stopped by cycle limit");
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        trans_in = '0;
        err_in = '0;
        param_load = 1'b0;
        param_addr = PD_A1;
        param_word = '0;
        repeat (RESET_CYCLES) @(posedge clk_in);
        #1;
        // Everything cleared straight out of reset
        check_value("drive_out", 32'(drive_out), 0);
        check_value("trans_lp_out", 32'(trans_lp_out), 0);
        check_value("unlocked", 32'(unlocked), 0);
        check_value("recent_unlock", 32'(recent_unlock), 0);
        reset = 1'b0;
        for (int ph = 0; ph < NUM_PHASES; ph++) begin
            for (int cyc = 0; cyc < PHASE_LEN; cyc++) begin
                trans_in = trans_sample(ph, cyc);
                err_in = sample_t'(rand_range(-4000, 4000));
                drive_loads(ph, cyc);
                @(posedge clk_in);
                #1;
            end
        end
        param_load = 1'b0;
        // Last compare happens at this negedge
        @(negedge clk_in);
        #1;
        $display("All tests passed!");
        $finish;
    end

endmodule

/* all.f */
+incdir+verif
src/servo_pkg.sv
src/param_if.sv
src/iir_stage.sv
src/param_bank.sv
src/relock_sweep.sv
src/lock_status.sv
src/pid_servo.sv
src/lock_servo_top.sv
verif/tb_lock_servo.sv

/* Makefile */
# Verilator build and run of the lock servo testbench
SRCS := $(wildcard src/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)

build/tb_lock_servo: all.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_lock_servo \
		-f all.f -Mdir build -o tb_lock_servo

run: build/tb_lock_servo
	./build/tb_lock_servo > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test failures found" sim.log; then exit 1; fi
	@grep -q "All tests passed!" sim.log

clean:
	rm -rf build sim.log

.PHONY: run clean
